// File: hw/capture_macros.svh
`ifndef CAPTURE_MACROS_SVH
`define CAPTURE_MACROS_SVH

// adc sample and packed output word
`define CAP_SAMPLE_W      12
`define CAP_WORD_W        64

// sample fifo entries, a power of two
`define CAP_FIFO_DEPTH    1024

// capture settings
`define CAP_PRESAMPLE_W   10
`define CAP_COUNT_W       20
`define CAP_DOWNSAMPLE_W  8

// sticky status vector
`define CAP_ERR_W         5

`endif

// File: hw/capture_pkg.sv
`include "capture_macros.svh"

package capture_pkg;

    typedef logic [`CAP_SAMPLE_W-1:0]     adc_sample_t;
    typedef logic [`CAP_WORD_W-1:0]       packed_word_t;
    typedef logic [`CAP_PRESAMPLE_W-1:0]  presample_t;
    typedef logic [`CAP_COUNT_W-1:0]      sample_count_t;
    typedef logic [`CAP_DOWNSAMPLE_W-1:0] downsample_t;
    typedef logic [`CAP_ERR_W-1:0]        err_stat_t;

    // capture sequencing
    typedef enum logic [2:0] {
        CAP_IDLE            = 3'd0,
        CAP_PRESAMP_FILLING = 3'd1,   // collecting the first P samples
        CAP_PRESAMP_FULL    = 3'd2,   // sliding window of P samples
        CAP_TRIGGERED       = 3'd3,
        CAP_DONE            = 3'd4
    } capture_state_e;

    // bit positions in err_stat_t
    localparam int ERR_FIFO_UNDERFLOW = 0;
    localparam int ERR_FIFO_OVERFLOW  = 1;
    localparam int ERR_PRESAMPLE      = 2;
    localparam int ERR_CLIP           = 3;
    localparam int ERR_DOWNSAMPLE     = 4;

endpackage

// File: hw/sample_fifo.sv
`timescale 1ns/1ns
`include "capture_macros.svh"

module sample_fifo (
    input  logic                     adc_sampleclk,
    input  logic                     reset,
    input  logic                     wr_i,
    input  capture_pkg::adc_sample_t din_i,
    input  logic                     rd_i,
    output capture_pkg::adc_sample_t dout_o,
    output logic                     full_o,
    output logic                     empty_o,
    output logic                     overflow_o,
    output logic                     underflow_o
);
    import capture_pkg::*;

    localparam int          DEPTH    = `CAP_FIFO_DEPTH;
    localparam int          AW       = $clog2(DEPTH);
    localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

    adc_sample_t   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_ok;
    logic          rd_ok;

    assign empty_o = (count == '0);
    assign full_o  = (count == FULL_CNT);

    assign rd_ok = rd_i && !empty_o;
    // a full fifo still takes a push when the head leaves in the same cycle
    assign wr_ok = wr_i && (!full_o || rd_ok);

    assign overflow_o  = wr_i && !wr_ok;   // push dropped
    assign underflow_o = rd_i && empty_o;

    assign dout_o = mem[rd_ptr];           // fall-through, head is always visible

    always_ff @(posedge adc_sampleclk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge adc_sampleclk) disable iff (reset)
        count <= FULL_CNT)
        else $error("sample fifo holds more than %0d entries", DEPTH);

endmodule

// File: hw/capture_ctrl.sv
`timescale 1ns/1ns

module capture_ctrl (
    input  logic                        adc_sampleclk,
    input  logic                        reset,
    input  logic                        arm_i,
    input  logic                        capture_go_i,
    input  capture_pkg::presample_t     presample_i,
    input  capture_pkg::sample_count_t  max_samples_i,
    input  capture_pkg::downsample_t    downsample_i,
    input  logic                        fifo_full_i,
    output logic                        sample_wr_o,
    output logic                        drain_o,
    output logic                        pack_en_o,
    output logic                        armed_o,
    output logic                        capture_stop_o,
    output logic                        capture_done_o,
    output capture_pkg::capture_state_e state_o,
    output logic                        presample_err_o,
    output logic                        downsample_err_o
);
    import capture_pkg::*;

    logic          arm_r;
    logic          arm_pulse;
    logic          go_r;
    logic          trig;
    logic          trig_taken;    // trigger seen in a state that accepts it
    downsample_t   ds_cnt;
    downsample_t   ds_eff;
    logic          keep;
    presample_t    pre_cnt;
    sample_count_t smp_cnt;
    sample_count_t trig_base;
    sample_count_t cnt_after;
    logic          wr_accepted;
    logic          last_wr;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r     <= 1'b0;
            arm_pulse <= 1'b0;
            go_r      <= 1'b0;
        end else begin
            arm_r     <= arm_i;
            arm_pulse <= arm_i && !arm_r;
            go_r      <= capture_go_i;
        end
    end

    // the sample on the rising edge of capture_go_i is the trigger sample
    assign trig = capture_go_i && !go_r;

    // presamples are not decimated, so D is ignored when both are set
    assign downsample_err_o = (downsample_i != '0) && (presample_i != '0);
    assign ds_eff           = downsample_err_o ? '0 : downsample_i;
    assign keep             = trig || (ds_cnt == ds_eff);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            ds_cnt <= '0;
        end else if (arm_pulse || keep) begin
            ds_cnt <= '0;   // restarts on the trigger too
        end else begin
            ds_cnt <= ds_cnt + 1'b1;
        end
    end

    always_comb begin
        case (state_o)
            CAP_IDLE:            sample_wr_o = armed_o && trig;
            CAP_PRESAMP_FILLING: sample_wr_o = keep;
            CAP_PRESAMP_FULL:    sample_wr_o = keep;
            CAP_TRIGGERED:       sample_wr_o = keep;
            default:             sample_wr_o = 1'b0;
        endcase
    end

    assign trig_taken = trig && ((state_o == CAP_IDLE && armed_o) ||
                                 state_o == CAP_PRESAMP_FILLING ||
                                 state_o == CAP_PRESAMP_FULL);

    // drop the oldest presample for every new one, except on the trigger
    assign drain_o   = (state_o == CAP_PRESAMP_FULL) && sample_wr_o && !trig;
    assign pack_en_o = (state_o == CAP_TRIGGERED) || (state_o == CAP_DONE);

    assign presample_err_o = trig && ((state_o == CAP_PRESAMP_FILLING) ||
                             (state_o == CAP_IDLE && armed_o && presample_i != '0));

    assign wr_accepted = sample_wr_o && !fifo_full_i;

    // samples already in the fifo when the trigger arrives
    always_comb begin
        case (state_o)
            CAP_PRESAMP_FULL:    trig_base = sample_count_t'(presample_i);
            CAP_PRESAMP_FILLING: trig_base = sample_count_t'(pre_cnt);
            default:             trig_base = '0;
        endcase
    end

    assign cnt_after = (state_o == CAP_TRIGGERED) ? smp_cnt + 1'b1 : trig_base + 1'b1;
    assign last_wr   = sample_wr_o && ((state_o == CAP_TRIGGERED) || trig_taken) &&
                       (cnt_after >= max_samples_i);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state_o        <= CAP_IDLE;
            pre_cnt        <= '0;
            smp_cnt        <= '0;
            armed_o        <= 1'b0;
            capture_stop_o <= 1'b0;
            capture_done_o <= 1'b0;
        end else if (arm_pulse) begin
            state_o        <= CAP_IDLE;   // also aborts a capture in progress
            pre_cnt        <= '0;
            smp_cnt        <= '0;
            armed_o        <= 1'b1;
            capture_stop_o <= 1'b0;
            capture_done_o <= 1'b0;
        end else begin
            if (last_wr) begin
                armed_o        <= 1'b0;
                capture_stop_o <= 1'b1;
                capture_done_o <= 1'b1;
            end
            if (trig_taken) begin
                smp_cnt <= cnt_after;
                state_o <= last_wr ? CAP_DONE : CAP_TRIGGERED;
            end else begin
                case (state_o)
                    CAP_IDLE: begin
                        if (armed_o && presample_i != '0) begin
                            pre_cnt <= '0;
                            state_o <= CAP_PRESAMP_FILLING;
                        end
                    end
                    CAP_PRESAMP_FILLING: begin
                        if (wr_accepted) begin
                            pre_cnt <= pre_cnt + 1'b1;
                            if (pre_cnt == presample_i - 1'b1) begin
                                state_o <= CAP_PRESAMP_FULL;   // P samples held
                            end
                        end
                    end
                    CAP_TRIGGERED: begin
                        if (sample_wr_o) begin
                            smp_cnt <= cnt_after;
                            if (last_wr) begin
                                state_o <= CAP_DONE;
                            end
                        end
                    end
                    default: ;   // full waits for the trigger, done for the next arm
                endcase
            end
        end
    end

    // a drain only happens once the window holds exactly P samples
    a_drain_full_window: assert property (@(posedge adc_sampleclk) disable iff (reset)
        drain_o |-> (state_o != CAP_IDLE) && (pre_cnt == presample_i))
        else $error("presample drain outside a full window");

endmodule

// File: hw/word_packer.sv
`timescale 1ns/1ns

module word_packer (
    input  logic                      adc_sampleclk,
    input  logic                      reset,
    input  logic                      pack_en_i,
    input  capture_pkg::adc_sample_t  sample_i,
    input  logic                      sample_avail_i,
    input  logic                      word_ready_i,
    output logic                      pop_o,
    output capture_pkg::packed_word_t word_data_o,
    output logic                      word_valid_o,
    output logic                      clip_o
);
    import capture_pkg::*;

    localparam int SMP_W = $bits(adc_sample_t);

    // phase 0: 5 samples + 4 bits, phase 1: 8 bits + 4 samples + 8 bits,
    // phase 2: 4 bits + 5 samples
    logic [71:0]  shifter;
    logic [71:0]  shifter_next;
    logic [1:0]   phase;
    logic [2:0]   phase_cnt;
    logic         phase_last;
    logic         room;
    packed_word_t word_next;

    assign room         = !word_valid_o || word_ready_i;   // output register frees up
    assign pop_o        = pack_en_i && sample_avail_i && room;
    assign shifter_next = {shifter[71-SMP_W:0], sample_i};
    assign phase_last   = (phase == 2'd0) ? (phase_cnt == 3'd5) : (phase_cnt == 3'd4);

    assign clip_o = pop_o && ((sample_i == '1) || (sample_i == '0));

    always_comb begin
        case (phase)
            2'd0:    word_next = shifter_next[71:8];
            2'd1:    word_next = shifter_next[67:4];
            default: word_next = shifter_next[63:0];
        endcase
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            phase        <= 2'd0;
            phase_cnt    <= 3'd0;
            word_valid_o <= 1'b0;
        end else begin
            if (word_valid_o && word_ready_i) begin
                word_valid_o <= 1'b0;
            end
            if (!pack_en_i) begin
                phase     <= 2'd0;   // drop any partial word
                phase_cnt <= 3'd0;
            end else if (pop_o) begin
                if (phase_last) begin
                    phase_cnt    <= 3'd0;
                    phase        <= (phase == 2'd2) ? 2'd0 : phase + 1'b1;
                    word_valid_o <= 1'b1;   // overrides the clear above
                end else begin
                    phase_cnt <= phase_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (pop_o) begin
            shifter <= shifter_next;
        end
        if (pop_o && phase_last) begin
            word_data_o <= word_next;
        end
    end

    a_word_hold: assert property (@(posedge adc_sampleclk) disable iff (reset)
        word_valid_o && !word_ready_i |=> word_valid_o && $stable(word_data_o))
        else $error("output word changed while stalled");

endmodule

// File: hw/capture_status.sv
`timescale 1ns/1ns

module capture_status (
    input  logic                   adc_sampleclk,
    input  logic                   reset,
    input  logic                   arm_i,
    input  logic                   clear_errors_i,
    input  logic                   no_clip_errors_i,
    input  logic                   overflow_i,
    input  logic                   underflow_i,
    input  logic                   presample_err_i,
    input  logic                   downsample_err_i,
    input  logic                   clip_i,
    output capture_pkg::err_stat_t error_stat_o,
    output logic                   error_flag_o
);
    import capture_pkg::*;

    logic      arm_r;
    logic      clear;
    err_stat_t events;
    err_stat_t keep_mask;

    always_comb begin
        events                     = '0;
        events[ERR_FIFO_UNDERFLOW] = underflow_i;
        events[ERR_FIFO_OVERFLOW]  = overflow_i;
        events[ERR_PRESAMPLE]      = presample_err_i;
        events[ERR_CLIP]           = clip_i;
        events[ERR_DOWNSAMPLE]     = downsample_err_i;
    end

    // clip reporting can be switched off, which also clears a set bit
    always_comb begin
        keep_mask           = '1;
        keep_mask[ERR_CLIP] = !no_clip_errors_i;
    end

    assign clear = (arm_i && !arm_r) || clear_errors_i;   // new arm starts clean

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r        <= 1'b0;
            error_stat_o <= '0;
            error_flag_o <= 1'b0;
        end else begin
            arm_r        <= arm_i;
            error_flag_o <= |error_stat_o;
            if (clear) begin
                error_stat_o <= '0;
            end else begin
                error_stat_o <= (error_stat_o | events) & keep_mask;   // sticky
            end
        end
    end

endmodule

// File: hw/adc_capture_top.sv
`timescale 1ns/1ns

module adc_capture_top (
    input  logic                        adc_sampleclk,
    input  logic                        reset,
    input  capture_pkg::adc_sample_t    adc_data_i,
    input  logic                        arm_i,
    input  logic                        capture_go_i,
    input  capture_pkg::presample_t     presample_i,
    input  capture_pkg::sample_count_t  max_samples_i,
    input  capture_pkg::downsample_t    downsample_i,
    input  logic                        clear_errors_i,
    input  logic                        no_clip_errors_i,
    input  logic                        word_ready_i,
    output capture_pkg::packed_word_t   word_data_o,
    output logic                        word_valid_o,
    output logic                        armed_o,
    output logic                        capture_stop_o,
    output logic                        capture_done_o,
    output capture_pkg::capture_state_e state_o,
    output logic                        error_flag_o,
    output capture_pkg::err_stat_t      error_stat_o
);
    import capture_pkg::*;

    adc_sample_t fifo_dout;
    logic        fifo_full;
    logic        fifo_empty;
    logic        fifo_rd;
    logic        fifo_overflow;
    logic        fifo_underflow;
    logic        sample_wr;
    logic        drain;
    logic        pack_en;
    logic        pop;
    logic        clip;
    logic        presample_err;
    logic        downsample_err;

    assign fifo_rd = pop | drain;   // never both, drain only before the trigger

    capture_ctrl u_ctrl (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .arm_i            (arm_i),
        .capture_go_i     (capture_go_i),
        .presample_i      (presample_i),
        .max_samples_i    (max_samples_i),
        .downsample_i     (downsample_i),
        .fifo_full_i      (fifo_full),
        .sample_wr_o      (sample_wr),
        .drain_o          (drain),
        .pack_en_o        (pack_en),
        .armed_o          (armed_o),
        .capture_stop_o   (capture_stop_o),
        .capture_done_o   (capture_done_o),
        .state_o          (state_o),
        .presample_err_o  (presample_err),
        .downsample_err_o (downsample_err)
    );

    sample_fifo u_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .wr_i          (sample_wr),
        .din_i         (adc_data_i),
        .rd_i          (fifo_rd),
        .dout_o        (fifo_dout),
        .full_o        (fifo_full),
        .empty_o       (fifo_empty),
        .overflow_o    (fifo_overflow),
        .underflow_o   (fifo_underflow)
    );

    word_packer u_packer (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .pack_en_i      (pack_en),
        .sample_i       (fifo_dout),
        .sample_avail_i (!fifo_empty),
        .word_ready_i   (word_ready_i),
        .pop_o          (pop),
        .word_data_o    (word_data_o),
        .word_valid_o   (word_valid_o),
        .clip_o         (clip)
    );

    capture_status u_status (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .arm_i            (arm_i),
        .clear_errors_i   (clear_errors_i),
        .no_clip_errors_i (no_clip_errors_i),
        .overflow_i       (fifo_overflow),
        .underflow_i      (fifo_underflow),
        .presample_err_i  (presample_err),
        .downsample_err_i (downsample_err),
        .clip_i           (clip),
        .error_stat_o     (error_stat_o),
        .error_flag_o     (error_flag_o)
    );

endmodule

// File: dv/capture_checker.sv
`timescale 1ns/1ns
`include "capture_macros.svh"

module capture_checker #(
    parameter int NUM_TESTS = 7
) (
    input  logic                        adc_sampleclk,
    input  logic                        reset,
    input  capture_pkg::adc_sample_t    adc_data_i,
    input  logic                        arm_i,
    input  logic                        capture_go_i,
    input  capture_pkg::presample_t     presample_i,
    input  capture_pkg::sample_count_t  max_samples_i,
    input  capture_pkg::downsample_t    downsample_i,
    input  capture_pkg::packed_word_t   word_data_i,
    input  logic                        word_valid_i,
    input  logic                        word_ready_i,
    input  logic                        armed_i,
    input  logic                        capture_stop_i,
    input  logic                        capture_done_i,
    input  capture_pkg::capture_state_e state_i,
    input  capture_pkg::err_stat_t      error_stat_i,
    input  logic                        error_flag_i,
    input  int                          test_idx_i,
    input  logic                        test_start_i,
    input  logic                        test_end_i,
    output int                          words_seen_o,
    output int                          err_count_o,
    output int                          fail_count_o
);
    import capture_pkg::*;

    localparam int SW = `CAP_SAMPLE_W;
    localparam int WW = `CAP_WORD_W;

    // same row order as the stimulus table
    string names [NUM_TESTS] = '{
        "basic", "presample", "downsample", "stall", "clip", "ds_error", "clear"
    };
    err_stat_t exp_stat [NUM_TESTS] = '{
        '0, '0, '0, '0,
        err_stat_t'(1 << ERR_CLIP),
        err_stat_t'(1 << ERR_DOWNSAMPLE),
        '0
    };

    adc_sample_t  hist [4096];   // adc input by cycle index
    int           cyc;
    int           trig_cyc;
    logic         go_prev;
    logic         arm_prev;
    logic         arm_edge_d1;   // arm_i rose one cycle ago
    logic         arm_edge_d2;
    logic         reset_check;   // first cycle out of reset
    int           test_errs;
    packed_word_t exp_word;

    function automatic int expected_words();
        return (int'(max_samples_i) * SW) / WW;   // partial last word is dropped
    endfunction

    // j-th sample that should reach the fifo, presamples first
    function automatic adc_sample_t kept_sample(input int j);
        int p;
        int step;
        int c;
        p    = int'(presample_i);
        step = (p != 0 && downsample_i != '0) ? 1 : int'(downsample_i) + 1;
        if (j < p) begin
            c = trig_cyc - p + j;
        end else begin
            c = trig_cyc + (j - p) * step;
        end
        return hist[c[11:0]];
    endfunction

    function automatic packed_word_t expected_word(input int w);
        packed_word_t word;
        adc_sample_t  smp;
        int           g;
        word = '0;
        for (int b = 0; b < WW; b++) begin
            g   = WW * w + b;   // offset in the msb-first bit stream
            smp = kept_sample(g / SW);
            word[WW - 1 - b] = smp[SW - 1 - (g % SW)];
        end
        return word;
    endfunction

    function void note_error();
        err_count_o++;
        test_errs++;
    endfunction

    function void compare_bit(input string tname, input string sig,
                              input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("** Error %s: %s expected %b actual %b", tname, sig, exp_v, act_v);
            note_error();
        end
    endfunction

    function void compare_state(input string tname, input capture_state_e exp_s);
        if (state_i !== exp_s) begin
            $display("** Error %s: state_o expected %0d actual %0d", tname, exp_s, state_i);
            note_error();
        end
    endfunction

    function void finish_test();
        err_stat_t exp_err;
        exp_err = exp_stat[test_idx_i];
        if (words_seen_o != expected_words()) begin
            $display("** Error %s: word count expected %0d actual %0d",
                     names[test_idx_i], expected_words(), words_seen_o);
            note_error();
        end
        if (max_samples_i != '0) begin
            compare_bit(names[test_idx_i], "capture_done_o", 1'b1, capture_done_i);
            compare_bit(names[test_idx_i], "capture_stop_o", 1'b1, capture_stop_i);
            compare_state(names[test_idx_i], CAP_DONE);
        end
        if (error_stat_i !== exp_err) begin
            $display("** Error %s: error_stat_o expected %b actual %b",
                     names[test_idx_i], exp_err, error_stat_i);
            note_error();
        end
        if (error_flag_i !== (|exp_err)) begin
            $display("** Error %s: error_flag_o expected %b actual %b",
                     names[test_idx_i], |exp_err, error_flag_i);
            note_error();
        end
        if (test_errs == 0) begin
            $display("test %-10s ok, %0d words", names[test_idx_i], words_seen_o);
        end else begin
            fail_count_o++;
            $display("test %-10s has %0d errors", names[test_idx_i], test_errs);
        end
    endfunction

    always @(posedge adc_sampleclk) begin
        if (reset) begin
            cyc          = 0;
            trig_cyc     = 0;
            go_prev      = 1'b0;
            arm_prev     = 1'b0;
            arm_edge_d1  = 1'b0;
            arm_edge_d2  = 1'b0;
            reset_check  = 1'b1;
            test_errs    = 0;
            words_seen_o = 0;
            err_count_o  = 0;
            fail_count_o = 0;
        end else begin
            hist[cyc[11:0]] = adc_data_i;
            if (reset_check) begin
                compare_bit("reset", "word_valid_o", 1'b0, word_valid_i);
                compare_bit("reset", "armed_o", 1'b0, armed_i);
                compare_bit("reset", "capture_stop_o", 1'b0, capture_stop_i);
                compare_bit("reset", "capture_done_o", 1'b0, capture_done_i);
                compare_bit("reset", "error_flag_o", 1'b0, error_flag_i);
                compare_state("reset", CAP_IDLE);
                reset_check = 1'b0;
            end
            if (test_start_i) begin
                words_seen_o = 0;
                test_errs    = 0;
            end
            // armed_o follows the arm edge by exactly two cycles
            if (arm_edge_d1) begin
                compare_bit(names[test_idx_i], "armed_o 1 cycle after arm", 1'b0, armed_i);
            end
            if (arm_edge_d2) begin
                compare_bit(names[test_idx_i], "armed_o 2 cycles after arm", 1'b1, armed_i);
            end
            arm_edge_d2 = arm_edge_d1;
            arm_edge_d1 = arm_i && !arm_prev;
            arm_prev    = arm_i;
            if (capture_go_i && !go_prev) begin
                trig_cyc = cyc;   // this cycle's sample is the trigger sample
            end
            go_prev = capture_go_i;
            if (word_valid_i && word_ready_i) begin
                if (words_seen_o >= expected_words()) begin
                    $display("** Error %s: word count expected %0d actual %0d",
                             names[test_idx_i], expected_words(), words_seen_o + 1);
                    note_error();
                end else begin
                    exp_word = expected_word(words_seen_o);
                    if (word_data_i !== exp_word) begin
                        $display("** Error %s: word %0d expected %h actual %h",
                                 names[test_idx_i], words_seen_o, exp_word, word_data_i);
                        note_error();
                    end
                end
                words_seen_o++;
            end
            if (test_end_i) begin
                finish_test();
            end
            cyc++;
        end
    end

endmodule

// File: dv/tb_adc_capture.sv
`timescale 1ns/1ns
`include "capture_macros.svh"

module tb_adc_capture;
    import capture_pkg::*;

    localparam int NUM_TESTS = 7;
    localparam int SETTLE    = 8;   // last pops and status registers land

    typedef struct packed {
        presample_t    p;
        sample_count_t n;       // 0 means no capture, only clear the status
        downsample_t   d;
        logic [7:0]    delay;   // cycles from armed_o to the trigger
        logic          stall;   // random back-pressure
        logic          clip;    // full scale samples mixed into the data
    } row_t;

    row_t rows [NUM_TESTS] = '{
        '{10'd0,  20'd48, 8'd0, 8'd5,  1'b0, 1'b0},
        '{10'd20, 20'd64, 8'd0, 8'd30, 1'b0, 1'b0},   // trigger after the window fills
        '{10'd0,  20'd32, 8'd3, 8'd7,  1'b0, 1'b0},
        '{10'd0,  20'd48, 8'd0, 8'd5,  1'b1, 1'b0},
        '{10'd0,  20'd40, 8'd0, 8'd5,  1'b0, 1'b1},   // 7 words, tail dropped
        '{10'd4,  20'd32, 8'd2, 8'd12, 1'b0, 1'b0},
        '{10'd0,  20'd0,  8'd0, 8'd0,  1'b0, 1'b0}
    };

    logic           adc_sampleclk = 1'b0;
    logic           reset;
    adc_sample_t    adc_data = '0;
    logic           arm;
    logic           capture_go;
    presample_t     presample;
    sample_count_t  max_samples;
    downsample_t    downsample;
    logic           clear_errors;
    logic           no_clip_errors;
    logic           word_ready = 1'b1;
    packed_word_t   word_data;
    logic           word_valid;
    logic           armed;
    logic           capture_stop;
    logic           capture_done;
    capture_state_e state;
    logic           error_flag;
    err_stat_t      error_stat;

    int   cycle = 0;
    int   limit = 0;
    logic cur_stall;
    logic cur_clip;
    int   test_idx;
    logic test_start;
    logic test_end;
    int   words_seen;
    int   err_count;
    int   fail_count;

    always #5 adc_sampleclk = ~adc_sampleclk;

    adc_capture_top UUT (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .adc_data_i       (adc_data),
        .arm_i            (arm),
        .capture_go_i     (capture_go),
        .presample_i      (presample),
        .max_samples_i    (max_samples),
        .downsample_i     (downsample),
        .clear_errors_i   (clear_errors),
        .no_clip_errors_i (no_clip_errors),
        .word_ready_i     (word_ready),
        .word_data_o      (word_data),
        .word_valid_o     (word_valid),
        .armed_o          (armed),
        .capture_stop_o   (capture_stop),
        .capture_done_o   (capture_done),
        .state_o          (state),
        .error_flag_o     (error_flag),
        .error_stat_o     (error_stat)
    );

    capture_checker #(.NUM_TESTS(NUM_TESTS)) u_checker (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .adc_data_i     (adc_data),
        .arm_i          (arm),
        .capture_go_i   (capture_go),
        .presample_i    (presample),
        .max_samples_i  (max_samples),
        .downsample_i   (downsample),
        .word_data_i    (word_data),
        .word_valid_i   (word_valid),
        .word_ready_i   (word_ready),
        .armed_i        (armed),
        .capture_stop_i (capture_stop),
        .capture_done_i (capture_done),
        .state_i        (state),
        .error_stat_i   (error_stat),
        .error_flag_i   (error_flag),
        .test_idx_i     (test_idx),
        .test_start_i   (test_start),
        .test_end_i     (test_end),
        .words_seen_o   (words_seen),
        .err_count_o    (err_count),
        .fail_count_o   (fail_count)
    );

    // cycle count doubles as the adc ramp and the timeout
    always @(posedge adc_sampleclk) begin
        cycle <= cycle + 1;
        if (cycle >= limit) begin
            $display("timeout after %0d cycles, capture or word stream stalled", cycle);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // adc model and ready pattern
    always @(negedge adc_sampleclk) begin
        if (cur_clip && cycle[3:0] == 4'd0) begin
            adc_data = 12'hFFF;
        end else begin
            adc_data = adc_sample_t'(100 + cycle);
        end
        word_ready = cur_stall ? ($urandom % 3 != 0) : 1'b1;
    end

    task automatic run_row(input int i);
        int nwords;
        nwords      = (int'(rows[i].n) * `CAP_SAMPLE_W) / `CAP_WORD_W;
        test_idx    = i;
        cur_stall   = rows[i].stall;
        cur_clip    = rows[i].clip;
        presample   = rows[i].p;
        max_samples = rows[i].n;
        downsample  = rows[i].d;
        test_start  = 1'b1;
        if (rows[i].n == '0) begin
            clear_errors = 1'b1;
            @(negedge adc_sampleclk);
            test_start   = 1'b0;
            clear_errors = 1'b0;
        end else begin
            arm = 1'b1;
            @(negedge adc_sampleclk);
            test_start = 1'b0;
            while (!armed) @(negedge adc_sampleclk);
            arm = 1'b0;
            repeat (rows[i].delay) @(negedge adc_sampleclk);
            capture_go = 1'b1;
            while (!capture_done) @(negedge adc_sampleclk);
            while (words_seen < nwords) @(negedge adc_sampleclk);
            capture_go = 1'b0;
        end
        repeat (SETTLE) @(negedge adc_sampleclk);
        test_end = 1'b1;
        @(negedge adc_sampleclk);
        test_end = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hA502_5A65));
        for (int i = 0; i < NUM_TESTS; i++) begin
            limit += (int'(rows[i].n) * (int'(rows[i].d) + 1) + int'(rows[i].p) +
                      int'(rows[i].delay)) * 4;
        end
        limit += 200;
        reset          = 1'b1;
        arm            = 1'b0;
        capture_go     = 1'b0;
        presample      = '0;
        max_samples    = '0;
        downsample     = '0;
        clear_errors   = 1'b0;
        no_clip_errors = 1'b0;
        cur_stall      = 1'b0;
        cur_clip       = 1'b0;
        test_idx       = 0;
        test_start     = 1'b0;
        test_end       = 1'b0;
        repeat (3) @(negedge adc_sampleclk);
        reset = 1'b0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_row(i);
        end
        $display("tests run %0d, tests failed %0d, errors %0d",
                 NUM_TESTS, fail_count, err_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+hw
hw/capture_pkg.sv
hw/sample_fifo.sv
hw/capture_ctrl.sv
hw/word_packer.sv
hw/capture_status.sv
hw/adc_capture_top.sv
dv/capture_checker.sv
dv/tb_adc_capture.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_adc_capture \
    -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_adc_capture)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
